//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f filelist.f --top-module saturnBusTb
	./obj_dir/VsaturnBusTb | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- busArbiter.sv
`timescale 1ns/1ns

module busArbiter (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  ceR,

	input  logic                  mshReq,
	input  logic                  mshWe,
	input  saturnBusPkg::cpuAddrT mshAddr,
	input  saturnBusPkg::busDataT mshWdata,
	input  saturnBusPkg::byteEnT  mshBe,
	output logic                  mshAck,
	output saturnBusPkg::busDataT mshRdata,

	input  logic                  sshReq,
	input  logic                  sshWe,
	input  saturnBusPkg::cpuAddrT sshAddr,
	input  saturnBusPkg::busDataT sshWdata,
	input  saturnBusPkg::byteEnT  sshBe,
	output logic                  sshAck,
	output saturnBusPkg::busDataT sshRdata,

	output logic                  accReq,
	output logic                  accWe,
	output saturnBusPkg::cpuAddrT accAddr,
	output saturnBusPkg::busDataT accWdata,
	output saturnBusPkg::byteEnT  accBe,
	input  logic                  accAck,
	input  saturnBusPkg::busDataT accRdata
);

	saturnCtrlPkg::arbStateT state;

	// Grant is held for the whole handshake of the owner
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= saturnCtrlPkg::ARB_IDLE;
		end else if (ceR) begin
			case (state)
				saturnCtrlPkg::ARB_IDLE: begin
					// Master CPU wins a tie
					if (mshReq) begin
						state <= saturnCtrlPkg::ARB_MASTER;
					end else if (sshReq) begin
						state <= saturnCtrlPkg::ARB_SLAVE;
					end
				end
				saturnCtrlPkg::ARB_MASTER: begin
					if (!mshReq && !accAck) begin
						state <= saturnCtrlPkg::ARB_IDLE;
					end
				end
				saturnCtrlPkg::ARB_SLAVE: begin
					if (!sshReq && !accAck) begin
						state <= saturnCtrlPkg::ARB_IDLE;
					end
				end
				default: state <= saturnCtrlPkg::ARB_IDLE;
			endcase
		end
	end

	always_comb begin
		accReq   = 1'b0;
		accWe    = 1'b0;
		accAddr  = '0;
		accWdata = '0;
		accBe    = '0;
		case (state)
			saturnCtrlPkg::ARB_MASTER: begin
				accReq   = mshReq;
				accWe    = mshWe;
				accAddr  = mshAddr;
				accWdata = mshWdata;
				accBe    = mshBe;
			end
			saturnCtrlPkg::ARB_SLAVE: begin
				accReq   = sshReq;
				accWe    = sshWe;
				accAddr  = sshAddr;
				accWdata = sshWdata;
				accBe    = sshBe;
			end
			default: ;
		endcase
	end

	// Response goes to the owner only
	assign mshAck   = (state == saturnCtrlPkg::ARB_MASTER) & accAck;
	assign sshAck   = (state == saturnCtrlPkg::ARB_SLAVE) & accAck;
	assign mshRdata = (state == saturnCtrlPkg::ARB_MASTER) ? accRdata : '0;
	assign sshRdata = (state == saturnCtrlPkg::ARB_SLAVE) ? accRdata : '0;

endmodule

//--- clockEnableGen.sv
`timescale 1ns/1ns

module clockEnableGen (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic pause,
	output logic ceR,
	output logic ceF,
	output logic smpcCe,
	output logic mresN
);

	logic run;
	logic phase;
	saturnCtrlPkg::divCntT divCnt;

	// Everything freezes while paused
	assign run = ce & ~pause;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (run) begin
			phase <= ~phase;
		end
	end

	assign ceR = run & phase;
	assign ceF = run & ~phase;

	// Divide ceR by seven for the register block
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCnt <= '0;
			smpcCe <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (ceR) begin
				if (divCnt == saturnCtrlPkg::SMPC_DIV - 3'd1) begin
					divCnt <= '0;
					smpcCe <= 1'b1;
				end else begin
					divCnt <= divCnt + 3'd1;
				end
			end
		end
	end

	// Register block leaves reset on the first divided tick
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresN <= 1'b0;
		end else if (smpcCe) begin
			mresN <= 1'b1;
		end
	end

endmodule

//--- filelist.f
saturnBusPkg.sv
saturnCtrlPkg.sv
clockEnableGen.sv
busArbiter.sv
memAccessCtrl.sv
smpcRegs.sv
saturnBus.sv
saturnBusTb.sv

//--- memAccessCtrl.sv
`timescale 1ns/1ns

module memAccessCtrl (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  ceR,

	input  logic                  accReq,
	input  logic                  accWe,
	input  saturnBusPkg::cpuAddrT accAddr,
	input  saturnBusPkg::busDataT accWdata,
	input  saturnBusPkg::byteEnT  accBe,
	output logic                  accAck,
	output saturnBusPkg::busDataT accRdata,

	output logic                  regReq,
	output logic                  regWe,
	output saturnBusPkg::regIdxT  regIdx,
	output saturnBusPkg::regDataT regWdata,
	input  logic                  regAck,
	input  saturnBusPkg::regDataT regRdata,

	output saturnBusPkg::memAddrT memAddr,
	output saturnBusPkg::busDataT memDo,
	input  saturnBusPkg::busDataT memDi,
	output saturnBusPkg::byteEnT  memDqmN,
	output logic                  memRdN,
	output logic                  romCsN,
	output logic                  sramCsN,
	output logic                  ramlCsN,
	output logic                  ramhCsN,
	input  logic                  memWaitN
);

	saturnCtrlPkg::accStateT state;
	saturnBusPkg::regionT    region;
	saturnBusPkg::regionT    decoded;
	saturnBusPkg::byteEnT    curBe;
	logic                    curWe;
	logic                    memCycle;

	function automatic logic inRange(input saturnBusPkg::cpuAddrT addr,
	                                 input saturnBusPkg::cpuAddrT lo,
	                                 input saturnBusPkg::cpuAddrT hi);
		return (addr >= lo) && (addr <= hi);
	endfunction

	function automatic saturnBusPkg::regionT regionOf(input saturnBusPkg::cpuAddrT addr);
		saturnBusPkg::regionT rgn;
		rgn = saturnBusPkg::RGN_NONE;
		if (inRange(addr, saturnBusPkg::ROM_BASE, saturnBusPkg::ROM_LIMIT))
			rgn = saturnBusPkg::RGN_ROM;
		else if (inRange(addr, saturnBusPkg::SMPC_BASE, saturnBusPkg::SMPC_LIMIT))
			rgn = saturnBusPkg::RGN_SMPC;
		else if (inRange(addr, saturnBusPkg::SRAM_BASE, saturnBusPkg::SRAM_LIMIT))
			rgn = saturnBusPkg::RGN_SRAM;
		else if (inRange(addr, saturnBusPkg::RAML_BASE, saturnBusPkg::RAML_LIMIT))
			rgn = saturnBusPkg::RGN_RAML;
		else if (inRange(addr, saturnBusPkg::RAMH_BASE, saturnBusPkg::RAMH_LIMIT))
			rgn = saturnBusPkg::RGN_RAMH;
		return rgn;
	endfunction

	assign decoded = regionOf(accAddr);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state  <= saturnCtrlPkg::ACC_IDLE;
			accAck <= 1'b0;
			regReq <= 1'b0;
		end else if (ceR) begin
			case (state)
				saturnCtrlPkg::ACC_IDLE: begin
					// Last register handshake must be closed first
					if (accReq && !regAck) begin
						case (decoded)
							saturnBusPkg::RGN_NONE: begin
								accAck <= 1'b1;
								state  <= saturnCtrlPkg::ACC_DONE;
							end
							saturnBusPkg::RGN_SMPC: begin
								regReq <= 1'b1;
								state  <= saturnCtrlPkg::ACC_REG;
							end
							default: state <= saturnCtrlPkg::ACC_MEM;
						endcase
					end
				end
				saturnCtrlPkg::ACC_MEM: begin
					// Cycle stretches while the memory holds wait low
					if (memWaitN) begin
						accAck <= 1'b1;
						state  <= saturnCtrlPkg::ACC_DONE;
					end
				end
				saturnCtrlPkg::ACC_REG: begin
					if (regAck) begin
						regReq <= 1'b0;
						accAck <= 1'b1;
						state  <= saturnCtrlPkg::ACC_DONE;
					end
				end
				saturnCtrlPkg::ACC_DONE: begin
					if (!accReq) begin
						accAck <= 1'b0;
						state  <= saturnCtrlPkg::ACC_IDLE;
					end
				end
				default: state <= saturnCtrlPkg::ACC_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (ceR) begin
			case (state)
				saturnCtrlPkg::ACC_IDLE: begin
					if (accReq && !regAck) begin
						region   <= decoded;
						memAddr  <= accAddr[24:0];
						memDo    <= accWdata;
						curWe    <= accWe;
						curBe    <= accBe;
						regIdx   <= accAddr[4:1];
						regWdata <= accWdata[7:0];
						accRdata <= saturnBusPkg::UNMAPPED_DATA;
					end
				end
				saturnCtrlPkg::ACC_MEM: if (memWaitN) accRdata <= memDi;
				// Register byte on all four lanes
				saturnCtrlPkg::ACC_REG: if (regAck) accRdata <= {4{regRdata}};
				default: ;
			endcase
		end
	end

	assign regWe    = curWe;
	assign memCycle = (state == saturnCtrlPkg::ACC_MEM);
	assign memRdN   = ~(memCycle & ~curWe);
	assign memDqmN  = (memCycle && curWe) ? ~curBe : '1;
	assign romCsN   = ~(memCycle && region == saturnBusPkg::RGN_ROM);
	assign sramCsN  = ~(memCycle && region == saturnBusPkg::RGN_SRAM);
	assign ramlCsN  = ~(memCycle && region == saturnBusPkg::RGN_RAML);
	assign ramhCsN  = ~(memCycle && region == saturnBusPkg::RGN_RAMH);

endmodule

//--- saturnBus.sv
`timescale 1ns/1ns

module saturnBus (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  ce,
	input  logic                  pause,

	input  logic                  mshReq,
	input  logic                  mshWe,
	input  saturnBusPkg::cpuAddrT mshAddr,
	input  saturnBusPkg::busDataT mshWdata,
	input  saturnBusPkg::byteEnT  mshBe,
	output logic                  mshAck,
	output saturnBusPkg::busDataT mshRdata,

	input  logic                  sshReq,
	input  logic                  sshWe,
	input  saturnBusPkg::cpuAddrT sshAddr,
	input  saturnBusPkg::busDataT sshWdata,
	input  saturnBusPkg::byteEnT  sshBe,
	output logic                  sshAck,
	output saturnBusPkg::busDataT sshRdata,

	output saturnBusPkg::memAddrT memAddr,
	output saturnBusPkg::busDataT memDo,
	input  saturnBusPkg::busDataT memDi,
	output saturnBusPkg::byteEnT  memDqmN,
	output logic                  memRdN,
	output logic                  romCsN,
	output logic                  sramCsN,
	output logic                  ramlCsN,
	output logic                  ramhCsN,
	input  logic                  memWaitN
);

	logic                  ceR;
	logic                  smpcCe;
	logic                  mresN;

	logic                  accReq;
	logic                  accWe;
	saturnBusPkg::cpuAddrT accAddr;
	saturnBusPkg::busDataT accWdata;
	saturnBusPkg::byteEnT  accBe;
	logic                  accAck;
	saturnBusPkg::busDataT accRdata;

	logic                  regReq;
	logic                  regWe;
	saturnBusPkg::regIdxT  regIdx;
	saturnBusPkg::regDataT regWdata;
	logic                  regAck;
	saturnBusPkg::regDataT regRdata;

	// Falling enable has no consumer on this bus
	clockEnableGen u_clockEnableGen (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.ce     (ce),
		.pause  (pause),
		.ceR    (ceR),
		.ceF    (),
		.smpcCe (smpcCe),
		.mresN  (mresN)
	);

	busArbiter u_busArbiter (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ceR      (ceR),
		.mshReq   (mshReq),
		.mshWe    (mshWe),
		.mshAddr  (mshAddr),
		.mshWdata (mshWdata),
		.mshBe    (mshBe),
		.mshAck   (mshAck),
		.mshRdata (mshRdata),
		.sshReq   (sshReq),
		.sshWe    (sshWe),
		.sshAddr  (sshAddr),
		.sshWdata (sshWdata),
		.sshBe    (sshBe),
		.sshAck   (sshAck),
		.sshRdata (sshRdata),
		.accReq   (accReq),
		.accWe    (accWe),
		.accAddr  (accAddr),
		.accWdata (accWdata),
		.accBe    (accBe),
		.accAck   (accAck),
		.accRdata (accRdata)
	);

	memAccessCtrl u_memAccessCtrl (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ceR      (ceR),
		.accReq   (accReq),
		.accWe    (accWe),
		.accAddr  (accAddr),
		.accWdata (accWdata),
		.accBe    (accBe),
		.accAck   (accAck),
		.accRdata (accRdata),
		.regReq   (regReq),
		.regWe    (regWe),
		.regIdx   (regIdx),
		.regWdata (regWdata),
		.regAck   (regAck),
		.regRdata (regRdata),
		.memAddr  (memAddr),
		.memDo    (memDo),
		.memDi    (memDi),
		.memDqmN  (memDqmN),
		.memRdN   (memRdN),
		.romCsN   (romCsN),
		.sramCsN  (sramCsN),
		.ramlCsN  (ramlCsN),
		.ramhCsN  (ramhCsN),
		.memWaitN (memWaitN)
	);

	smpcRegs u_smpcRegs (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.smpcCe   (smpcCe),
		.mresN    (mresN),
		.regReq   (regReq),
		.regWe    (regWe),
		.regIdx   (regIdx),
		.regWdata (regWdata),
		.regAck   (regAck),
		.regRdata (regRdata)
	);

endmodule

//--- saturnBusPkg.sv
package saturnBusPkg;

	// CPU side byte address
	typedef logic [26:0] cpuAddrT;

	// External memory address from the low CPU address bits
	typedef logic [24:0] memAddrT;

	typedef logic [31:0] busDataT;

	// Active high byte lane enables
	typedef logic [3:0]  byteEnT;

	// System manager register index from address bits 4..1
	typedef logic [3:0]  regIdxT;
	typedef logic [7:0]  regDataT;

	typedef enum logic [2:0] {
		RGN_ROM  = 3'd0,
		RGN_SMPC = 3'd1,
		RGN_SRAM = 3'd2,
		RGN_RAML = 3'd3,
		RGN_RAMH = 3'd4,
		RGN_NONE = 3'd5
	} regionT;

	// Address map of the shared bus
	localparam cpuAddrT ROM_BASE   = 27'h0000000;
	localparam cpuAddrT ROM_LIMIT  = 27'h00FFFFF;

	localparam cpuAddrT SMPC_BASE  = 27'h0100000;
	localparam cpuAddrT SMPC_LIMIT = 27'h017FFFF;

	localparam cpuAddrT SRAM_BASE  = 27'h0180000;
	localparam cpuAddrT SRAM_LIMIT = 27'h01FFFFF;

	localparam cpuAddrT RAML_BASE  = 27'h0200000;
	localparam cpuAddrT RAML_LIMIT = 27'h02FFFFF;

	localparam cpuAddrT RAMH_BASE  = 27'h6000000;
	localparam cpuAddrT RAMH_LIMIT = 27'h7FFFFFF;

	// Read value for holes in the map
	localparam busDataT UNMAPPED_DATA = 32'hFFFF_FFFF;

endpackage

//--- saturnBusTb.sv
`timescale 1ns/1ns

module saturnBusTb;

	// Chip select masks with bits in the order rom sram raml ramh
	localparam logic [3:0] CS_NONE = 4'b0000;
	localparam logic [3:0] CS_ROM  = 4'b1000;
	localparam logic [3:0] CS_SRAM = 4'b0100;
	localparam logic [3:0] CS_RAML = 4'b0010;
	localparam logic [3:0] CS_RAMH = 4'b0001;

	// Worst case per transfer is a register access on the divided enable
	localparam int XFER_CYCLES = 60;
	localparam int XFER_COUNT  = 22;
	localparam int CYCLE_LIMIT = XFER_COUNT * XFER_CYCLES + 16 + 20 + 200;

	logic                  CLK;
	logic                  RST_N;
	logic                  ce;
	logic                  pause;
	logic                  mshReq;
	logic                  mshWe;
	saturnBusPkg::cpuAddrT mshAddr;
	saturnBusPkg::busDataT mshWdata;
	saturnBusPkg::byteEnT  mshBe;
	logic                  mshAck;
	saturnBusPkg::busDataT mshRdata;
	logic                  sshReq;
	logic                  sshWe;
	saturnBusPkg::cpuAddrT sshAddr;
	saturnBusPkg::busDataT sshWdata;
	saturnBusPkg::byteEnT  sshBe;
	logic                  sshAck;
	saturnBusPkg::busDataT sshRdata;
	saturnBusPkg::memAddrT memAddr;
	saturnBusPkg::busDataT memDo;
	saturnBusPkg::busDataT memDi;
	saturnBusPkg::byteEnT  memDqmN;
	logic                  memRdN;
	logic                  romCsN;
	logic                  sramCsN;
	logic                  ramlCsN;
	logic                  ramhCsN;
	logic                  memWaitN;

	// What the bus showed during the current transfer
	logic [3:0]            obsCs;
	saturnBusPkg::memAddrT obsAddr;
	saturnBusPkg::busDataT obsDo;
	saturnBusPkg::byteEnT  obsDqmN;
	logic                  obsRdLow;

	logic [31:0]           lfsr = 32'h9434;
	logic [2:0]            waitLeft = '0;
	logic                  inCycle = 1'b0;
	int                    cycleCount = 0;

	saturnBus u_saturnBus (.*);

	always #2 CLK = ~CLK;

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic saturnBusPkg::busDataT memModel(input saturnBusPkg::cpuAddrT addr);
		return {7'd0, addr[24:0]} ^ 32'hA5A5_0000;
	endfunction

	// Memory model with address based data and a random wait per cycle
	always @(posedge CLK) begin
		#1;
		memDi = {7'd0, memAddr} ^ 32'hA5A5_0000;
		if ({romCsN, sramCsN, ramlCsN, ramhCsN} != 4'hF) begin
			if (!inCycle) begin
				inCycle = 1'b1;
				for (int i = 0; i < 3; i++) begin
					waitLeft = {waitLeft[1:0], lfsr[0]};
					lfsr = lfsrStep(lfsr);
				end
			end else if (waitLeft != 3'd0) begin
				waitLeft = waitLeft - 3'd1;
			end
			memWaitN = (waitLeft == 3'd0);
		end else begin
			inCycle = 1'b0;
			memWaitN = 1'b1;
		end
	end

	task automatic stopRun();
		$display("Test failed");
		$fatal(1);
	endtask

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount == CYCLE_LIMIT) begin
			$display("Timeout: the DUT did not finish its transfers within %0d cycles",
				CYCLE_LIMIT);
			stopRun();
		end
	end

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic clearObs();
		obsCs    = CS_NONE;
		obsAddr  = '0;
		obsDo    = '0;
		obsDqmN  = '1;
		obsRdLow = 1'b0;
	endtask

	task automatic observeBus();
		logic [3:0] csNow;
		csNow = ~{romCsN, sramCsN, ramlCsN, ramhCsN};
		obsCs = obsCs | csNow;
		if (csNow != CS_NONE) begin
			obsAddr = memAddr;
			obsDo   = memDo;
			obsDqmN = memDqmN;
		end
		if (!memRdN)
			obsRdLow = 1'b1;
	endtask

	function automatic logic ackOf(input logic slave);
		return slave ? sshAck : mshAck;
	endfunction

	task automatic startReq(input logic slave, input logic we, input saturnBusPkg::cpuAddrT addr,
	                        input saturnBusPkg::busDataT wdata, input saturnBusPkg::byteEnT be);
		if (slave) begin
			sshWe    = we;
			sshAddr  = addr;
			sshWdata = wdata;
			sshBe    = be;
			sshReq   = 1'b1;
		end else begin
			mshWe    = we;
			mshAddr  = addr;
			mshWdata = wdata;
			mshBe    = be;
			mshReq   = 1'b1;
		end
	endtask

	// Rest of the four-phase cycle once req is up
	task automatic finishXfer(input logic slave, output saturnBusPkg::busDataT rdata);
		do begin
			@(posedge CLK);
			#1;
			observeBus();
		end while (!ackOf(slave));
		rdata = slave ? sshRdata : mshRdata;
		if (slave)
			sshReq = 1'b0;
		else
			mshReq = 1'b0;
		do begin
			@(posedge CLK);
			#1;
			observeBus();
		end while (ackOf(slave));
	endtask

	task automatic checkResetState();
		checkEq("mshAck", 32'(mshAck), 32'd0);
		checkEq("sshAck", 32'(sshAck), 32'd0);
		checkEq("chip selects", 32'({romCsN, sramCsN, ramlCsN, ramhCsN}), 32'hF);
		checkEq("memRdN", 32'(memRdN), 32'd1);
		checkEq("memDqmN", 32'(memDqmN), 32'hF);
	endtask

	task automatic readMem(input saturnBusPkg::cpuAddrT addr, input logic [3:0] expCs);
		saturnBusPkg::busDataT rd;
		clearObs();
		startReq(1'b0, 1'b0, addr, '0, 4'hF);
		finishXfer(1'b0, rd);
		checkEq("mshRdata", rd, memModel(addr));
		checkEq("chip selects", 32'(obsCs), 32'(expCs));
		checkEq("memAddr", 32'(obsAddr), 32'(addr[24:0]));
		assert (obsRdLow) else begin
			$display("memRdN never went low during a memory read");
			stopRun();
		end
	endtask

	task automatic writeMem(input saturnBusPkg::cpuAddrT addr, input saturnBusPkg::busDataT wdata,
	                        input saturnBusPkg::byteEnT be, input logic [3:0] expCs);
		saturnBusPkg::busDataT rd;
		saturnBusPkg::byteEnT  expDqm;
		expDqm = ~be;
		clearObs();
		startReq(1'b0, 1'b1, addr, wdata, be);
		finishXfer(1'b0, rd);
		checkEq("chip selects", 32'(obsCs), 32'(expCs));
		checkEq("memAddr", 32'(obsAddr), 32'(addr[24:0]));
		checkEq("memDo", obsDo, wdata);
		checkEq("memDqmN", 32'(obsDqmN), 32'(expDqm));
		assert (!obsRdLow) else begin
			$display("memRdN went low during a memory write");
			stopRun();
		end
	endtask

	task automatic regWrite(input logic [3:0] idx, input logic [7:0] data);
		saturnBusPkg::busDataT rd;
		clearObs();
		startReq(1'b0, 1'b1, 27'h0100000 | {22'd0, idx, 1'b0}, {24'hDEADBE, data}, 4'b0001);
		finishXfer(1'b0, rd);
		checkEq("chip selects", 32'(obsCs), 32'(CS_NONE));
	endtask

	task automatic regRead(input logic [3:0] idx, input logic [7:0] expByte);
		saturnBusPkg::busDataT rd;
		clearObs();
		startReq(1'b0, 1'b0, 27'h0100000 | {22'd0, idx, 1'b0}, '0, 4'hF);
		finishXfer(1'b0, rd);
		checkEq("mshRdata", rd, {4{expByte}});
		checkEq("chip selects", 32'(obsCs), 32'(CS_NONE));
	endtask

	task automatic regionReads();
		readMem(27'h0012344, CS_ROM);
		readMem(27'h01A5678, CS_SRAM);
		readMem(27'h02ABCD0, CS_RAML);
		readMem(27'h7F12344, CS_RAMH);
	endtask

	task automatic memWrites();
		writeMem(27'h0190010, 32'h1234_5678, 4'b1111, CS_SRAM);
		writeMem(27'h0200400, 32'hCAFE_F00D, 4'b0011, CS_RAML);
		writeMem(27'h6400008, 32'h0BAD_BEEF, 4'b1100, CS_RAMH);
	endtask

	task automatic registerAccess();
		regRead(4'd9, 8'h00);
		regWrite(4'd1, 8'h3C);
		regWrite(4'd6, 8'hA7);
		regWrite(4'd11, 8'h5E);
		regWrite(4'd15, 8'h81);
		regRead(4'd1, 8'h3C);
		regRead(4'd6, 8'hA7);
		regRead(4'd11, 8'h5E);
		regRead(4'd15, 8'h81);
	endtask

	task automatic arbitrationTie();
		saturnBusPkg::busDataT rd;
		startReq(1'b0, 1'b0, 27'h0054320, '0, 4'hF);
		startReq(1'b1, 1'b0, 27'h0212340, '0, 4'hF);
		do begin
			@(posedge CLK);
			#1;
			checkEq("sshAck", 32'(sshAck), 32'd0);
		end while (!mshAck);
		checkEq("mshRdata", mshRdata, memModel(27'h0054320));
		mshReq = 1'b0;
		do begin
			@(posedge CLK);
			#1;
			checkEq("sshAck", 32'(sshAck), 32'd0);
		end while (mshAck);
		finishXfer(1'b1, rd);
		checkEq("sshRdata", rd, memModel(27'h0212340));
	endtask

	task automatic slaveHoldsGrant();
		saturnBusPkg::busDataT rd;
		startReq(1'b1, 1'b0, 27'h6001230, '0, 4'hF);
		// Slave owns the bus once its cycle is on the pins
		do begin
			@(posedge CLK);
			#1;
		end while (ramhCsN);
		startReq(1'b0, 1'b0, 27'h0000100, '0, 4'hF);
		do begin
			@(posedge CLK);
			#1;
			checkEq("mshAck", 32'(mshAck), 32'd0);
		end while (!sshAck);
		checkEq("sshRdata", sshRdata, memModel(27'h6001230));
		sshReq = 1'b0;
		do begin
			@(posedge CLK);
			#1;
			checkEq("mshAck", 32'(mshAck), 32'd0);
		end while (sshAck);
		finishXfer(1'b0, rd);
		checkEq("mshRdata", rd, memModel(27'h0000100));
	endtask

	task automatic pauseHold();
		saturnBusPkg::busDataT rd;
		clearObs();
		pause = 1'b1;
		startReq(1'b0, 1'b0, 27'h0280040, '0, 4'hF);
		repeat (20) begin
			@(posedge CLK);
			#1;
			observeBus();
			checkEq("mshAck", 32'(mshAck), 32'd0);
		end
		checkEq("chip selects", 32'(obsCs), 32'(CS_NONE));
		pause = 1'b0;
		finishXfer(1'b0, rd);
		checkEq("mshRdata", rd, memModel(27'h0280040));
		checkEq("chip selects", 32'(obsCs), 32'(CS_RAML));
	endtask

	task automatic unmappedRead();
		saturnBusPkg::busDataT rd;
		clearObs();
		startReq(1'b0, 1'b0, 27'h0400000, '0, 4'hF);
		finishXfer(1'b0, rd);
		checkEq("mshRdata", rd, 32'hFFFF_FFFF);
		checkEq("chip selects", 32'(obsCs), 32'(CS_NONE));
	endtask

	initial begin
		CLK      = 1'b0;
		RST_N    = 1'b0;
		ce       = 1'b1;
		pause    = 1'b0;
		mshReq   = 1'b0;
		mshWe    = 1'b0;
		mshAddr  = '0;
		mshWdata = '0;
		mshBe    = '0;
		sshReq   = 1'b0;
		sshWe    = 1'b0;
		sshAddr  = '0;
		sshWdata = '0;
		sshBe    = '0;
		memDi    = '0;
		memWaitN = 1'b1;
		clearObs();
		repeat (16) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		checkResetState();
		regionReads();
		memWrites();
		registerAccess();
		arbitrationTie();
		slaveHoldsGrant();
		pauseHold();
		unmappedRead();
		$display("Test passed");
		$finish;
	end

endmodule

//--- saturnCtrlPkg.sv
package saturnCtrlPkg;

	// Divider counter width
	typedef logic [2:0] divCntT;

	// ceR ticks per system manager tick
	localparam divCntT SMPC_DIV = 3'd7;

	// Bus grant
	typedef enum logic [1:0] {
		ARB_IDLE   = 2'd0,
		ARB_MASTER = 2'd1,
		ARB_SLAVE  = 2'd2
	} arbStateT;

	// Access sequencing
	typedef enum logic [1:0] {
		ACC_IDLE = 2'd0,
		ACC_MEM  = 2'd1,
		ACC_REG  = 2'd2,
		ACC_DONE = 2'd3
	} accStateT;

endpackage

//--- smpcRegs.sv
`timescale 1ns/1ns

module smpcRegs (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  smpcCe,
	input  logic                  mresN,
	input  logic                  regReq,
	input  logic                  regWe,
	input  saturnBusPkg::regIdxT  regIdx,
	input  saturnBusPkg::regDataT regWdata,
	output logic                  regAck,
	output saturnBusPkg::regDataT regRdata
);

	saturnBusPkg::regDataT regFile [16];
	logic                  tick;
	logic                  access;

	// Block only runs once out of its own reset
	assign tick   = smpcCe & mresN;
	assign access = tick & regReq & ~regAck;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			regAck <= 1'b0;
		end else if (tick) begin
			if (regReq && !regAck) begin
				regAck <= 1'b1;
			end else if (!regReq && regAck) begin
				regAck <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!mresN) begin
			for (int i = 0; i < 16; i++) begin
				regFile[i] <= '0;
			end
		end else if (access && regWe) begin
			regFile[regIdx] <= regWdata;
		end
	end

	// Writes echo the written byte
	always_ff @(posedge CLK) begin
		if (access) begin
			regRdata <= regWe ? regWdata : regFile[regIdx];
		end
	end

endmodule
